// ==== mul_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// latency 2, the whole pipeline stalls while stage 2 is refused
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_array #(
  parameter int HARD_THREAD = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   batch_valid_i,
  output logic                                   batch_ready_o,
  input  logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_a_i,
  input  logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_b_i,
  input  logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_c_i,
  input  logic [HARD_THREAD-1:0]                 batch_mask_i,
  input  vmul_pkg::mul_ctrl_t                    batch_ctrl_i,
  output logic                                   prod_valid_o,
  input  logic                                   prod_ready_i,
  output logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  prod_data_o,
  output vmul_pkg::mul_ctrl_t                    prod_ctrl_o,
  output logic [HARD_THREAD-1:0]                 prod_mask_o
);
  import vmul_pkg::*;

  logic                   adv;
  logic                   v1_q;
  logic                   v2_q;
  mul_ctrl_t              ctrl1_q;
  mul_ctrl_t              ctrl2_q;
  logic [HARD_THREAD-1:0] mask1_q;
  logic [HARD_THREAD-1:0] mask2_q;

  // common advance for every lane
  assign adv           = ~v2_q | prod_ready_i;
  assign batch_ready_o = adv;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (adv) begin
      v1_q <= batch_valid_i;
      v2_q <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      ctrl1_q <= batch_ctrl_i;
      mask1_q <= batch_mask_i;
      ctrl2_q <= ctrl1_q;
      mask2_q <= mask1_q;
    end
  end

  for (genvar i = 0; i < HARD_THREAD; i++) begin : g_lane
    mul_lane i_lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .en_i     (adv),
      .op_i     (batch_ctrl_i.op),
      .a_i      (batch_a_i[i*XLEN +: XLEN]),
      .b_i      (batch_b_i[i*XLEN +: XLEN]),
      .c_i      (batch_c_i[i*XLEN +: XLEN]),
      .result_o (prod_data_o[i*XLEN +: XLEN])
    );
  end

  assign prod_valid_o = v2_q;
  assign prod_ctrl_o  = ctrl2_q;
  assign prod_mask_o  = mask2_q;

endmodule

// ==== mul_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two register stages, both frozen while en_i is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_lane (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en_i,
  input  vmul_pkg::mul_op_e         op_i,
  input  logic [vmul_pkg::XLEN-1:0] a_i,
  input  logic [vmul_pkg::XLEN-1:0] b_i,
  input  logic [vmul_pkg::XLEN-1:0] c_i,
  output logic [vmul_pkg::XLEN-1:0] result_o
);
  import vmul_pkg::*;

  logic                 a_sgn;
  logic                 b_sgn;
  logic signed [XLEN:0] a_ext;
  logic signed [XLEN:0] b_ext;
  logic [2*XLEN-1:0]    prod_w;
  logic [2*XLEN-1:0]    prod_q;
  logic [XLEN-1:0]      c_q;
  mul_op_e              op_q;
  logic [XLEN-1:0]      res_w;

  // operand signedness per op, low product ignores it
  always_comb begin
    a_sgn = 1'b0;
    b_sgn = 1'b0;
    case (op_i)
      MUL_HSS: begin
        a_sgn = 1'b1;
        b_sgn = 1'b1;
      end
      MUL_HSU: a_sgn = 1'b1;
      default: ;
    endcase
  end

  assign a_ext  = {a_sgn & a_i[XLEN-1], a_i};
  assign b_ext  = {b_sgn & b_i[XLEN-1], b_i};
  // 33x33 signed product, the low 64 bits hold every case exactly
  assign prod_w = a_ext * b_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_q <= MUL_LO;
    end else if (en_i) begin
      op_q <= op_i;
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      prod_q <= prod_w;
      c_q    <= c_i;
    end
  end

  always_comb begin
    case (op_q)
      MUL_LO:  res_w = prod_q[XLEN-1:0];
      MUL_ACC: res_w = prod_q[XLEN-1:0] + c_q;
      default: res_w = prod_q[2*XLEN-1:XLEN];
    endcase
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      result_o <= res_w;
    end
  end

endmodule

// ==== operand_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SOFT_THREAD must be a multiple of HARD_THREAD
// an instruction with neither wvd nor wxd is accepted and dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_sequencer #(
  parameter int SOFT_THREAD = 8,
  parameter int HARD_THREAD = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0]  in1_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0]  in2_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0]  in3_i,
  input  logic [SOFT_THREAD-1:0]                 mask_i,
  input  vmul_pkg::mul_ctrl_t                    ctrl_i,
  output logic                                   batch_valid_o,
  input  logic                                   batch_ready_i,
  output logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_a_o,
  output logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_b_o,
  output logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  batch_c_o,
  output logic [HARD_THREAD-1:0]                 batch_mask_o,
  output vmul_pkg::mul_ctrl_t                    batch_ctrl_o
);
  import vmul_pkg::*;

  localparam int MAX_ITER = SOFT_THREAD / HARD_THREAD;
  localparam int CNT_W    = $clog2(MAX_ITER + 1);
  localparam int BATCH_W  = HARD_THREAD * XLEN;

  logic [SOFT_THREAD*XLEN-1:0] op1_q;
  logic [SOFT_THREAD*XLEN-1:0] op2_q;
  logic [SOFT_THREAD*XLEN-1:0] op3_q;
  logic [SOFT_THREAD-1:0]      mask_q;
  mul_ctrl_t                   ctrl_q;
  // batches still to send
  logic [CNT_W-1:0]            cnt_q;
  logic                        accept;
  logic                        fire;

  assign batch_valid_o = (cnt_q != '0);
  assign fire          = batch_valid_o & batch_ready_i;
  // idle, or the last batch leaves this cycle
  assign in_ready_o    = (cnt_q == '0) | (fire & (cnt_q == CNT_W'(1)));
  assign accept        = in_valid_i & in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (accept) begin
      if (ctrl_i.wvd) begin
        cnt_q <= CNT_W'(MAX_ITER);
      end else if (ctrl_i.wxd) begin
        cnt_q <= CNT_W'(1);
      end else begin
        cnt_q <= '0;
      end
    end else if (fire) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // operands move down one batch per transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      op1_q  <= in1_i;
      op2_q  <= in2_i;
      op3_q  <= in3_i;
      mask_q <= mask_i;
      ctrl_q <= ctrl_i;
    end else if (fire) begin
      op1_q  <= op1_q >> BATCH_W;
      op2_q  <= op2_q >> BATCH_W;
      op3_q  <= op3_q >> BATCH_W;
      mask_q <= mask_q >> HARD_THREAD;
    end
  end

  // reverse swaps the first and second operands
  assign batch_a_o    = ctrl_q.reverse ? op2_q[BATCH_W-1:0] : op1_q[BATCH_W-1:0];
  assign batch_b_o    = ctrl_q.reverse ? op1_q[BATCH_W-1:0] : op2_q[BATCH_W-1:0];
  assign batch_c_o    = op3_q[BATCH_W-1:0];
  assign batch_mask_o = mask_q[HARD_THREAD-1:0];
  assign batch_ctrl_o = ctrl_q;

endmodule

// ==== result_collector.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// batches must arrive in thread order, lowest threads first
// a scalar result is lane 0 of its single batch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_collector #(
  parameter int SOFT_THREAD = 8,
  parameter int HARD_THREAD = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   prod_valid_i,
  output logic                                   prod_ready_o,
  input  logic [HARD_THREAD*vmul_pkg::XLEN-1:0]  prod_data_i,
  input  vmul_pkg::mul_ctrl_t                    prod_ctrl_i,
  input  logic [HARD_THREAD-1:0]                 prod_mask_i,
  output logic                                   x_push_o,
  input  logic                                   x_push_ready_i,
  output vmul_pkg::wbx_t                         x_data_o,
  output logic                                   v_push_o,
  input  logic                                   v_push_ready_i,
  output logic [vmul_pkg::DEPTH_WARP+vmul_pkg::REG_IDX_W+
                SOFT_THREAD*(vmul_pkg::XLEN+1)-1:0] v_data_o
);
  import vmul_pkg::*;

  localparam int MAX_ITER = SOFT_THREAD / HARD_THREAD;
  localparam int CNT_W    = $clog2(MAX_ITER + 1);
  localparam int VEC_W    = SOFT_THREAD * XLEN;

  typedef struct packed {
    logic [DEPTH_WARP-1:0]  wid;
    logic [REG_IDX_W-1:0]   reg_idxw;
    logic [SOFT_THREAD-1:0] mask;
    logic [VEC_W-1:0]       data;
  } outv_t;

  logic [VEC_W-1:0]       res_q;
  logic [SOFT_THREAD-1:0] mask_q;
  mul_ctrl_t              ctrl_q;
  // batches received of the current instruction
  logic [CNT_W-1:0]       cnt_q;
  // finished result waiting for its buffer
  logic                   done_q;
  logic                   out_fire;
  logic                   in_fire;
  logic                   last_batch;
  outv_t                  v_res;

  assign out_fire     = done_q & (ctrl_q.wvd ? v_push_ready_i : x_push_ready_i);
  assign prod_ready_o = ~done_q | out_fire;
  assign in_fire      = prod_valid_i & prod_ready_o;
  assign last_batch   = ~prod_ctrl_i.wvd | (cnt_q == CNT_W'(MAX_ITER - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      if (in_fire) begin
        cnt_q <= last_batch ? '0 : cnt_q + CNT_W'(1);
      end
      if (in_fire && last_batch) begin
        done_q <= 1'b1;
      end else if (out_fire) begin
        done_q <= 1'b0;
      end
    end
  end

  // new batch enters at the top, older ones move down
  always_ff @(posedge clk) begin
    if (in_fire) begin
      res_q  <= VEC_W'({prod_data_i, res_q} >> (HARD_THREAD * XLEN));
      mask_q <= SOFT_THREAD'({prod_mask_i, mask_q} >> HARD_THREAD);
      ctrl_q <= prod_ctrl_i;
    end
  end

  assign x_push_o          = done_q & ~ctrl_q.wvd;
  assign x_data_o.wid      = ctrl_q.wid;
  assign x_data_o.reg_idxw = ctrl_q.reg_idxw;
  assign x_data_o.data     = res_q[(SOFT_THREAD-HARD_THREAD)*XLEN +: XLEN];

  assign v_push_o       = done_q & ctrl_q.wvd;
  assign v_res.wid      = ctrl_q.wid;
  assign v_res.reg_idxw = ctrl_q.reg_idxw;
  assign v_res.mask     = mask_q;
  assign v_res.data     = res_q;
  assign v_data_o       = v_res;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_vmul -f vlog.f --Mdir obj_dir -o sim_vmul
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_vmul > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "no pass line found in sim.log"
  exit 1
fi
exit 0

// ==== tb_vmul.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8 soft threads on 2 lanes with random stimulus and output ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_vmul;
  import vmul_pkg::*;

  localparam int          SOFT_THREAD  = 8;
  localparam int          HARD_THREAD  = 2;
  localparam int          MAX_ITER     = SOFT_THREAD / HARD_THREAD;
  localparam int          N_INSTR      = 400;
  localparam int          CLK_PERIOD   = 8;
  localparam int          DRAIN_CYCLES = 500;
  localparam int          WATCHDOG_NS  = N_INSTR * (MAX_ITER + 10) * CLK_PERIOD * 4;
  localparam logic [31:0] SEED         = 32'h6329_63cf;

  logic                        clk;
  logic                        rst_n;
  logic                        in_valid_i;
  logic                        in_ready_o;
  logic [SOFT_THREAD*XLEN-1:0] in1_i;
  logic [SOFT_THREAD*XLEN-1:0] in2_i;
  logic [SOFT_THREAD*XLEN-1:0] in3_i;
  logic [SOFT_THREAD-1:0]      mask_i;
  mul_ctrl_t                   ctrl_i;
  logic                        outx_valid_o;
  logic                        outx_ready_i = 1'b0;
  wbx_t                        outx_o;
  logic                        outv_valid_o;
  logic                        outv_ready_i = 1'b0;
  logic [DEPTH_WARP-1:0]       outv_wid_o;
  logic [REG_IDX_W-1:0]        outv_reg_idxw_o;
  logic [SOFT_THREAD-1:0]      outv_mask_o;
  logic [SOFT_THREAD*XLEN-1:0] outv_data_o;
  logic                        final_chk;
  int                          err_cnt;
  int                          x_cnt;
  int                          v_cnt;
  int                          x_left;
  int                          v_left;
  logic [31:0]                 stim_state = SEED;
  logic [31:0]                 ready_state = SEED;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], stim_state[0]};
      stim_state = lfsr_next(stim_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] draw_ready(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], ready_state[0]};
      ready_state = lfsr_next(ready_state);
    end
    return v;
  endfunction

  always #(CLK_PERIOD / 2) clk = ~clk;

  // sinks ready about three cycles in four
  always @(posedge clk) begin
    outx_ready_i <= |draw_ready(2);
    outv_ready_i <= |draw_ready(2);
  end

  vmul_unit #(
    .SOFT_THREAD (SOFT_THREAD),
    .HARD_THREAD (HARD_THREAD)
  ) i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .in1_i           (in1_i),
    .in2_i           (in2_i),
    .in3_i           (in3_i),
    .mask_i          (mask_i),
    .ctrl_i          (ctrl_i),
    .outx_valid_o    (outx_valid_o),
    .outx_ready_i    (outx_ready_i),
    .outx_o          (outx_o),
    .outv_valid_o    (outv_valid_o),
    .outv_ready_i    (outv_ready_i),
    .outv_wid_o      (outv_wid_o),
    .outv_reg_idxw_o (outv_reg_idxw_o),
    .outv_mask_o     (outv_mask_o),
    .outv_data_o     (outv_data_o)
  );

  vmul_checker #(
    .SOFT_THREAD (SOFT_THREAD)
  ) i_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .in_ready_i      (in_ready_o),
    .in1_i           (in1_i),
    .in2_i           (in2_i),
    .in3_i           (in3_i),
    .mask_i          (mask_i),
    .ctrl_i          (ctrl_i),
    .outx_valid_i    (outx_valid_o),
    .outx_ready_i    (outx_ready_i),
    .outx_i          (outx_o),
    .outv_valid_i    (outv_valid_o),
    .outv_ready_i    (outv_ready_i),
    .outv_wid_i      (outv_wid_o),
    .outv_reg_idxw_i (outv_reg_idxw_o),
    .outv_mask_i     (outv_mask_o),
    .outv_data_i     (outv_data_o),
    .final_i         (final_chk),
    .err_cnt_o       (err_cnt),
    .x_cnt_o         (x_cnt),
    .v_cnt_o         (v_cnt),
    .x_left_o        (x_left),
    .v_left_o        (v_left)
  );

  // one random instruction held until the DUT takes it
  task automatic send_instr();
    logic [SOFT_THREAD*XLEN-1:0] v1;
    logic [SOFT_THREAD*XLEN-1:0] v2;
    logic [SOFT_THREAD*XLEN-1:0] v3;
    mul_ctrl_t                   c;
    logic [2:0]                  op_val;
    logic [2:0]                  flag_sel;
    logic [31:0]                 r;
    for (int t = 0; t < SOFT_THREAD; t++) begin
      v1[t*XLEN +: XLEN] = draw_bits(XLEN);
      v2[t*XLEN +: XLEN] = draw_bits(XLEN);
      v3[t*XLEN +: XLEN] = draw_bits(XLEN);
    end
    op_val     = 3'(draw_bits(3) % 32'd5);
    c.op       = mul_op_e'(op_val);
    r          = draw_bits(1);
    c.reverse  = r[0];
    c.wid      = DEPTH_WARP'(draw_bits(DEPTH_WARP));
    c.reg_idxw = REG_IDX_W'(draw_bits(REG_IDX_W));
    flag_sel   = 3'(draw_bits(3));
    // mostly vector, some scalar, a few with both or neither
    case (flag_sel)
      3'd0:       {c.wvd, c.wxd} = 2'b00;
      3'd1, 3'd2: {c.wvd, c.wxd} = 2'b01;
      3'd3:       {c.wvd, c.wxd} = 2'b11;
      default:    {c.wvd, c.wxd} = 2'b10;
    endcase
    in_valid_i <= 1'b1;
    in1_i      <= v1;
    in2_i      <= v2;
    in3_i      <= v3;
    mask_i     <= SOFT_THREAD'(draw_bits(SOFT_THREAD));
    ctrl_i     <= c;
    @(posedge clk);
    while (!in_ready_o) @(posedge clk);
    in_valid_i <= 1'b0;
    r = draw_bits(2);
    if (r[1:0] == 2'd0) @(posedge clk);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid_i = 1'b0;
    in1_i      = '0;
    in2_i      = '0;
    in3_i      = '0;
    mask_i     = '0;
    ctrl_i     = '0;
    final_chk  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int n = 0; n < N_INSTR; n++) begin
      send_instr();
    end
    for (int k = 0; k < DRAIN_CYCLES && (x_left != 0 || v_left != 0); k++) begin
      @(posedge clk);
    end
    // a few more cycles to catch stray outputs
    repeat (10) @(posedge clk);
    final_chk <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("checked %0d scalar and %0d vector results, %0d errors", x_cnt, v_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
vmul_pkg.sv
wb_buffer.sv
mul_lane.sv
mul_array.sv
operand_sequencer.sv
result_collector.sv
vmul_unit.sv
vmul_checker.sv
tb_vmul.sv

// ==== vmul_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// own multiply model, results expected in acceptance order per path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vmul_checker #(
  parameter int SOFT_THREAD = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_valid_i,
  input  logic                                  in_ready_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in1_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in2_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in3_i,
  input  logic [SOFT_THREAD-1:0]                mask_i,
  input  vmul_pkg::mul_ctrl_t                   ctrl_i,
  input  logic                                  outx_valid_i,
  input  logic                                  outx_ready_i,
  input  vmul_pkg::wbx_t                        outx_i,
  input  logic                                  outv_valid_i,
  input  logic                                  outv_ready_i,
  input  logic [vmul_pkg::DEPTH_WARP-1:0]       outv_wid_i,
  input  logic [vmul_pkg::REG_IDX_W-1:0]        outv_reg_idxw_i,
  input  logic [SOFT_THREAD-1:0]                outv_mask_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] outv_data_i,
  input  logic                                  final_i,
  output int                                    err_cnt_o,
  output int                                    x_cnt_o,
  output int                                    v_cnt_o,
  output int                                    x_left_o,
  output int                                    v_left_o
);
  import vmul_pkg::*;

  typedef struct packed {
    logic [DEPTH_WARP-1:0]       wid;
    logic [REG_IDX_W-1:0]        reg_idxw;
    logic [SOFT_THREAD-1:0]      mask;
    logic [SOFT_THREAD*XLEN-1:0] data;
  } exp_v_t;

  wbx_t   exp_x_q[$];
  exp_v_t exp_v_q[$];
  int     err_cnt = 0;
  int     x_cnt = 0;
  int     v_cnt = 0;
  int     x_left = 0;
  int     v_left = 0;
  logic   reset_seen = 1'b0;
  logic   final_done = 1'b0;

  assign err_cnt_o = err_cnt;
  assign x_cnt_o   = x_cnt;
  assign v_cnt_o   = v_cnt;
  assign x_left_o  = x_left;
  assign v_left_o  = v_left;

  // full 64-bit products, operands extended by the op's signedness
  function automatic logic [XLEN-1:0] model_op(input mul_op_e op, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b,
                                               input logic [XLEN-1:0] c);
    logic [2*XLEN-1:0] a_s;
    logic [2*XLEN-1:0] b_s;
    logic [2*XLEN-1:0] a_u;
    logic [2*XLEN-1:0] b_u;
    logic [2*XLEN-1:0] p;
    a_s = {{XLEN{a[XLEN-1]}}, a};
    b_s = {{XLEN{b[XLEN-1]}}, b};
    a_u = {{XLEN{1'b0}}, a};
    b_u = {{XLEN{1'b0}}, b};
    case (op)
      MUL_HSS: p = a_s * b_s;
      MUL_HSU: p = a_s * b_u;
      default: p = a_u * b_u;
    endcase
    case (op)
      MUL_LO:  return p[XLEN-1:0];
      MUL_ACC: return p[XLEN-1:0] + c;
      default: return p[2*XLEN-1:XLEN];
    endcase
  endfunction

  task automatic fail_value(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] got_val);
    $display("[FAIL] %s expected 0x%h got 0x%h", name, exp_val, got_val);
    err_cnt++;
  endtask

  task automatic push_expected();
    exp_v_t          ev;
    wbx_t            ex;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    ev.wid      = ctrl_i.wid;
    ev.reg_idxw = ctrl_i.reg_idxw;
    ev.mask     = mask_i;
    for (int t = 0; t < SOFT_THREAD; t++) begin
      a = ctrl_i.reverse ? in2_i[t*XLEN +: XLEN] : in1_i[t*XLEN +: XLEN];
      b = ctrl_i.reverse ? in1_i[t*XLEN +: XLEN] : in2_i[t*XLEN +: XLEN];
      ev.data[t*XLEN +: XLEN] = model_op(ctrl_i.op, a, b, in3_i[t*XLEN +: XLEN]);
    end
    // vector wins when both flags are set
    if (ctrl_i.wvd) begin
      exp_v_q.push_back(ev);
    end else if (ctrl_i.wxd) begin
      ex.wid      = ev.wid;
      ex.reg_idxw = ev.reg_idxw;
      ex.data     = ev.data[XLEN-1:0];
      exp_x_q.push_back(ex);
    end
  endtask

  task automatic check_scalar();
    wbx_t e;
    if (exp_x_q.size() == 0) begin
      $display("ERROR: a scalar result came out with no instruction waiting for it");
      err_cnt++;
      return;
    end
    e = exp_x_q.pop_front();
    x_cnt++;
    if (outx_i.wid !== e.wid)
      fail_value("outx_o.wid", XLEN'(e.wid), XLEN'(outx_i.wid));
    if (outx_i.reg_idxw !== e.reg_idxw)
      fail_value("outx_o.reg_idxw", XLEN'(e.reg_idxw), XLEN'(outx_i.reg_idxw));
    if (outx_i.data !== e.data)
      fail_value("outx_o.data", e.data, outx_i.data);
  endtask

  task automatic check_vector();
    exp_v_t e;
    if (exp_v_q.size() == 0) begin
      $display("ERROR: a vector result came out with no instruction waiting for it");
      err_cnt++;
      return;
    end
    e = exp_v_q.pop_front();
    v_cnt++;
    if (outv_wid_i !== e.wid)
      fail_value("outv_wid_o", XLEN'(e.wid), XLEN'(outv_wid_i));
    if (outv_reg_idxw_i !== e.reg_idxw)
      fail_value("outv_reg_idxw_o", XLEN'(e.reg_idxw), XLEN'(outv_reg_idxw_i));
    if (outv_mask_i !== e.mask)
      fail_value("outv_mask_o", XLEN'(e.mask), XLEN'(outv_mask_i));
    for (int t = 0; t < SOFT_THREAD; t++) begin
      if (outv_data_i[t*XLEN +: XLEN] !== e.data[t*XLEN +: XLEN])
        fail_value($sformatf("outv_data_o[%0d]", t), e.data[t*XLEN +: XLEN],
                   outv_data_i[t*XLEN +: XLEN]);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // first edge out of reset still shows the reset state
      if (!reset_seen) begin
        if (outx_valid_i !== 1'b0)
          fail_value("outx_valid_o", '0, XLEN'(outx_valid_i));
        if (outv_valid_i !== 1'b0)
          fail_value("outv_valid_o", '0, XLEN'(outv_valid_i));
        if (in_ready_i !== 1'b1)
          fail_value("in_ready_o", XLEN'(1), XLEN'(in_ready_i));
        reset_seen = 1'b1;
      end
      if (in_valid_i && in_ready_i)
        push_expected();
      if (outx_valid_i && outx_ready_i)
        check_scalar();
      if (outv_valid_i && outv_ready_i)
        check_vector();
      if (final_i && !final_done) begin
        if (exp_x_q.size() != 0) begin
          $display("ERROR: %0d scalar results never came out", exp_x_q.size());
          err_cnt++;
        end
        if (exp_v_q.size() != 0) begin
          $display("ERROR: %0d vector results never came out", exp_v_q.size());
          err_cnt++;
        end
        final_done = 1'b1;
      end
      x_left = exp_x_q.size();
      v_left = exp_v_q.size();
    end
  end

endmodule

// ==== vmul_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths and tags of the vector multiply unit
// the vector payload depends on SOFT_THREAD and lives in the modules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vmul_pkg;

  // data word width
  localparam int XLEN = 32;
  // warp id width
  localparam int DEPTH_WARP = 3;
  // register index plus extension bits
  localparam int REG_IDX_W = 8;

  // multiply operations kept from the full alu decode
  typedef enum logic [2:0] {
    MUL_LO  = 3'd0,
    MUL_HSS = 3'd1,
    MUL_HUU = 3'd2,
    MUL_HSU = 3'd3,
    MUL_ACC = 3'd4
  } mul_op_e;

  // tag of one instruction, travels with every batch
  typedef struct packed {
    mul_op_e                 op;
    logic                    reverse;
    logic [DEPTH_WARP-1:0]   wid;
    logic [REG_IDX_W-1:0]    reg_idxw;
    logic                    wvd;
    logic                    wxd;
  } mul_ctrl_t;

  // scalar writeback
  typedef struct packed {
    logic [DEPTH_WARP-1:0]   wid;
    logic [REG_IDX_W-1:0]    reg_idxw;
    logic [XLEN-1:0]         data;
  } wbx_t;

endpackage

// ==== vmul_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// results leave in acceptance order on each path, latency varies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vmul_unit #(
  parameter int SOFT_THREAD = 8,
  parameter int HARD_THREAD = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in1_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in2_i,
  input  logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] in3_i,
  input  logic [SOFT_THREAD-1:0]                mask_i,
  input  vmul_pkg::mul_ctrl_t                   ctrl_i,
  output logic                                  outx_valid_o,
  input  logic                                  outx_ready_i,
  output vmul_pkg::wbx_t                        outx_o,
  output logic                                  outv_valid_o,
  input  logic                                  outv_ready_i,
  output logic [vmul_pkg::DEPTH_WARP-1:0]       outv_wid_o,
  output logic [vmul_pkg::REG_IDX_W-1:0]        outv_reg_idxw_o,
  output logic [SOFT_THREAD-1:0]                outv_mask_o,
  output logic [SOFT_THREAD*vmul_pkg::XLEN-1:0] outv_data_o
);
  import vmul_pkg::*;

  typedef struct packed {
    logic [DEPTH_WARP-1:0]       wid;
    logic [REG_IDX_W-1:0]        reg_idxw;
    logic [SOFT_THREAD-1:0]      mask;
    logic [SOFT_THREAD*XLEN-1:0] data;
  } outv_t;

  logic                        batch_valid;
  logic                        batch_ready;
  logic [HARD_THREAD*XLEN-1:0] batch_a;
  logic [HARD_THREAD*XLEN-1:0] batch_b;
  logic [HARD_THREAD*XLEN-1:0] batch_c;
  logic [HARD_THREAD-1:0]      batch_mask;
  mul_ctrl_t                   batch_ctrl;
  logic                        prod_valid;
  logic                        prod_ready;
  logic [HARD_THREAD*XLEN-1:0] prod_data;
  mul_ctrl_t                   prod_ctrl;
  logic [HARD_THREAD-1:0]      prod_mask;
  logic                        x_push;
  logic                        x_push_ready;
  wbx_t                        x_data;
  logic                        v_push;
  logic                        v_push_ready;
  outv_t                       v_data;
  outv_t                       v_out;

  operand_sequencer #(
    .SOFT_THREAD (SOFT_THREAD),
    .HARD_THREAD (HARD_THREAD)
  ) i_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in1_i         (in1_i),
    .in2_i         (in2_i),
    .in3_i         (in3_i),
    .mask_i        (mask_i),
    .ctrl_i        (ctrl_i),
    .batch_valid_o (batch_valid),
    .batch_ready_i (batch_ready),
    .batch_a_o     (batch_a),
    .batch_b_o     (batch_b),
    .batch_c_o     (batch_c),
    .batch_mask_o  (batch_mask),
    .batch_ctrl_o  (batch_ctrl)
  );

  mul_array #(
    .HARD_THREAD (HARD_THREAD)
  ) i_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .batch_valid_i (batch_valid),
    .batch_ready_o (batch_ready),
    .batch_a_i     (batch_a),
    .batch_b_i     (batch_b),
    .batch_c_i     (batch_c),
    .batch_mask_i  (batch_mask),
    .batch_ctrl_i  (batch_ctrl),
    .prod_valid_o  (prod_valid),
    .prod_ready_i  (prod_ready),
    .prod_data_o   (prod_data),
    .prod_ctrl_o   (prod_ctrl),
    .prod_mask_o   (prod_mask)
  );

  result_collector #(
    .SOFT_THREAD (SOFT_THREAD),
    .HARD_THREAD (HARD_THREAD)
  ) i_coll (
    .clk            (clk),
    .rst_n          (rst_n),
    .prod_valid_i   (prod_valid),
    .prod_ready_o   (prod_ready),
    .prod_data_i    (prod_data),
    .prod_ctrl_i    (prod_ctrl),
    .prod_mask_i    (prod_mask),
    .x_push_o       (x_push),
    .x_push_ready_i (x_push_ready),
    .x_data_o       (x_data),
    .v_push_o       (v_push),
    .v_push_ready_i (v_push_ready),
    .v_data_o       (v_data)
  );

  // scalar path
  wb_buffer #(
    .payload_t (wbx_t)
  ) i_xbuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (x_push),
    .push_ready_o (x_push_ready),
    .data_i       (x_data),
    .valid_o      (outx_valid_o),
    .ready_i      (outx_ready_i),
    .data_o       (outx_o)
  );

  // vector path
  wb_buffer #(
    .payload_t (outv_t)
  ) i_vbuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (v_push),
    .push_ready_o (v_push_ready),
    .data_i       (v_data),
    .valid_o      (outv_valid_o),
    .ready_i      (outv_ready_i),
    .data_o       (v_out)
  );

  assign outv_wid_o      = v_out.wid;
  assign outv_reg_idxw_o = v_out.reg_idxw;
  assign outv_mask_o     = v_out.mask;
  assign outv_data_o     = v_out.data;

endmodule

// ==== wb_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one entry, refills in the cycle the held entry leaves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_i,
  output logic     push_ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  assign push_ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (push_i && push_ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && push_ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule
